// File: design/keypad_config.svh
`ifndef KEYPAD_CONFIG_SVH
`define KEYPAD_CONFIG_SVH

// Cycles each column stays driven before the rows are sampled
// Must be at least 3 so the two-flop synchronizer has settled
`define KP_SCAN_DWELL 4

// Digits kept in one entry
`define KP_MAX_DIGITS 4

// Entry value width, 14 bits holds 9999
`define KP_VALUE_W 14

`endif

// File: design/keypad_pkg.sv
`include "keypad_config.svh"

package keypad_pkg;

    // Scanner output, one valid cycle per press
    typedef struct packed {
        logic       valid;
        logic [7:0] code;     // Row bits, then column drive
    } scan_event_t;

    typedef enum logic [1:0] {
        kc_digit,
        kc_letter,
        kc_clear,
        kc_submit
    } key_class_t;

    // Decoder output
    typedef struct packed {
        logic       valid;
        logic [7:0] char;     // ASCII
        key_class_t kclass;
        logic [3:0] digit;    // Only meaningful for kc_digit
    } key_event_t;

    // Entry handed to the host
    typedef struct packed {
        logic [`KP_VALUE_W-1:0] value;
        logic [2:0]             ndigits;
        logic [7:0]             cmd;      // Zero when no letter was pressed
    } entry_t;

endpackage

// File: design/keypad_scan.sv
`timescale 1ns/1ps
`include "keypad_config.svh"

module keypad_scan
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    input  logic        enable,
    input  logic [3:0]  rows,
    output logic [3:0]  cols,
    output scan_event_t scan
);
    localparam int dwell = `KP_SCAN_DWELL;
    localparam int cnt_w = $clog2(dwell);

    logic [3:0]       rows_meta;
    logic [3:0]       rows_sync;
    logic [cnt_w-1:0] dwell_cnt;
    logic [1:0]       col_idx;
    logic             held;        // Wait state, column frozen on a pressed key
    logic             sample_now;
    logic             new_press;
    logic             scan_valid;
    logic [7:0]       scan_code;

    assign sample_now = enable && (dwell_cnt == cnt_w'(dwell - 1));
    assign new_press  = sample_now && !held && (rows_sync != 4'b0000);

    // One column low at a time
    always_comb begin
        case (col_idx)
            2'd0:    cols = 4'b1110;
            2'd1:    cols = 4'b1101;
            2'd2:    cols = 4'b1011;
            default: cols = 4'b0111;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            rows_meta <= 4'b0000;
            rows_sync <= 4'b0000;
        end else begin
            rows_meta <= rows;        // Rows are asynchronous to clk
            rows_sync <= rows_meta;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            dwell_cnt  <= '0;
            col_idx    <= 2'd0;
            held       <= 1'b0;
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= 1'b0;
            if (enable) begin
                dwell_cnt <= sample_now ? '0 : dwell_cnt + 1'b1;
            end
            if (sample_now) begin
                if (!held) begin
                    if (rows_sync != 4'b0000) begin
                        scan_valid <= 1'b1;
                        held       <= 1'b1;    // Hold this column until release
                    end else begin
                        col_idx <= col_idx + 2'd1;
                    end
                end else if (rows_sync == 4'b0000) begin
                    held    <= 1'b0;
                    col_idx <= col_idx + 2'd1;
                end
            end
        end
    end

    // Rows seen in this dwell belong to the column driven now
    always_ff @(posedge clk) begin
        if (new_press) begin
            scan_code <= {rows_sync, cols};
        end
    end

    always_comb begin
        scan.valid = scan_valid;
        scan.code  = scan_code;
    end

endmodule

// File: design/key_decode.sv
`timescale 1ns/1ps

module key_decode
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    input  scan_event_t scan,
    output key_event_t  key
);
    logic [7:0] char_c;
    key_class_t kclass_c;
    logic       key_valid;
    logic [7:0] key_char;
    key_class_t key_kclass;
    logic [3:0] key_digit;

    // Several or no row bits fall through to zero
    always_comb begin
        case (scan.code)
            8'b0001_1110: char_c = "1";
            8'b0010_1110: char_c = "4";
            8'b0100_1110: char_c = "7";
            8'b1000_1110: char_c = "*";
            8'b0001_1101: char_c = "2";
            8'b0010_1101: char_c = "5";
            8'b0100_1101: char_c = "8";
            8'b1000_1101: char_c = "0";
            8'b0001_1011: char_c = "3";
            8'b0010_1011: char_c = "6";
            8'b0100_1011: char_c = "9";
            8'b1000_1011: char_c = "#";
            8'b0001_0111: char_c = "A";
            8'b0010_0111: char_c = "B";
            8'b0100_0111: char_c = "C";
            8'b1000_0111: char_c = "D";
            default:      char_c = 8'h00;
        endcase
    end

    always_comb begin
        kclass_c = kc_digit;
        if (char_c >= "A" && char_c <= "D") begin
            kclass_c = kc_letter;
        end else if (char_c == "*") begin
            kclass_c = kc_clear;
        end else if (char_c == "#") begin
            kclass_c = kc_submit;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            key_valid <= 1'b0;
        end else begin
            key_valid <= scan.valid && (char_c != 8'h00);
        end
    end

    always_ff @(posedge clk) begin
        if (scan.valid) begin
            key_char   <= char_c;
            key_kclass <= kclass_c;
            key_digit  <= char_c[3:0];    // ASCII 0-9 carry the value in the low nibble
        end
    end

    always_comb begin
        key.valid  = key_valid;
        key.char   = key_char;
        key.kclass = key_kclass;
        key.digit  = key_digit;
    end

endmodule

// File: design/entry_assemble.sv
`timescale 1ns/1ps
`include "keypad_config.svh"

module entry_assemble
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  key_event_t key,
    input  logic       busy,
    output logic       submit,
    output entry_t     entry
);
    localparam int value_w = `KP_VALUE_W;

    logic [value_w-1:0] value;
    logic [2:0]         ndigits;
    logic [7:0]         cmd;
    logic               accept_submit;
    logic               room;

    assign room          = (ndigits < 3'(`KP_MAX_DIGITS));
    assign accept_submit = key.valid && (key.kclass == kc_submit) && !busy;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            value   <= '0;
            ndigits <= 3'd0;
            cmd     <= 8'h00;
            submit  <= 1'b0;
        end else begin
            submit <= 1'b0;
            if (key.valid) begin
                case (key.kclass)
                    kc_digit: begin
                        if (room) begin               // Extra digits are dropped
                            value   <= value * value_w'(10) + value_w'(key.digit);
                            ndigits <= ndigits + 3'd1;
                        end
                    end
                    kc_letter: begin
                        cmd <= key.char;
                    end
                    kc_clear: begin
                        value   <= '0;
                        ndigits <= 3'd0;
                        cmd     <= 8'h00;
                    end
                    kc_submit: begin
                        // While the host port is busy the # is lost, entry kept
                        if (!busy) begin
                            submit  <= 1'b1;
                            value   <= '0;
                            ndigits <= 3'd0;
                            cmd     <= 8'h00;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Snapshot taken alongside the submit pulse
    always_ff @(posedge clk) begin
        if (accept_submit) begin
            entry.value   <= value;
            entry.ndigits <= ndigits;
            entry.cmd     <= cmd;
        end
    end

endmodule

// File: design/host_port.sv
`timescale 1ns/1ps

module host_port
    import keypad_pkg::*;
(
    input  logic   clk,
    input  logic   nRST,
    input  logic   submit,
    input  entry_t entry_in,
    output logic   busy,
    output logic   req,
    input  logic   ack,
    output entry_t entry
);
    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_release
    } host_state_t;

    host_state_t state;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (submit) state <= st_request;
                st_request: if (ack) state <= st_release;      // Drop req once acked
                st_release: if (!ack) state <= st_idle;       // Four-phase return to zero
                default:    state <= st_idle;
            endcase
        end
    end

    // Held constant for the whole request
    always_ff @(posedge clk) begin
        if (submit && state == st_idle) begin
            entry <= entry_in;
        end
    end

    assign req  = (state == st_request);
    assign busy = (state != st_idle);

endmodule

// File: design/keypad_entry_top.sv
`timescale 1ns/1ps

module keypad_entry_top
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic       enable,
    input  logic [3:0] rows,
    output logic [3:0] cols,
    output logic       req,
    input  logic       ack,
    output entry_t     entry
);
    scan_event_t scan;
    key_event_t  key;
    logic        submit;
    logic        busy;
    entry_t      entry_sub;

    keypad_scan u_scan (
        .clk    (clk),
        .nRST   (nRST),
        .enable (enable),
        .rows   (rows),
        .cols   (cols),
        .scan   (scan)
    );

    key_decode u_decode (
        .clk    (clk),
        .nRST   (nRST),
        .scan   (scan),
        .key    (key)
    );

    entry_assemble u_assemble (
        .clk    (clk),
        .nRST   (nRST),
        .key    (key),
        .busy   (busy),        // Back-pressure from the host side
        .submit (submit),
        .entry  (entry_sub)
    );

    host_port u_host (
        .clk      (clk),
        .nRST     (nRST),
        .submit   (submit),
        .entry_in (entry_sub),
        .busy     (busy),
        .req      (req),
        .ack      (ack),
        .entry    (entry)
    );

endmodule

// File: test/keypad_entry_sva.sv
`timescale 1ns/1ps

module keypad_entry_sva
    import keypad_pkg::*;
(
    input logic       clk,
    input logic       nRST,
    input logic [3:0] cols,
    input logic       req,
    input logic       ack,
    input entry_t     entry
);
    one_col_low: assert property (@(posedge clk) disable iff (!nRST)
        $countones(~cols) == 1)
        else $error("cols drives %b, not exactly one low bit", cols);

    req_until_ack: assert property (@(posedge clk) disable iff (!nRST)
        req && !ack |=> req)
        else $error("req dropped before ack");

    // Host reads entry any time during the request
    entry_stable: assert property (@(posedge clk) disable iff (!nRST)
        req |=> !req || $stable(entry))
        else $error("entry changed during a request");

    // Ack as seen on the edge where req was raised
    no_rise_on_ack: assert property (@(posedge clk) disable iff (!nRST)
        $rose(req) |-> !$past(ack))
        else $error("req rose while ack was still high");

endmodule

bind keypad_entry_top keypad_entry_sva sva (
    .clk   (clk),
    .nRST  (nRST),
    .cols  (cols),
    .req   (req),
    .ack   (ack),
    .entry (entry)
);

// File: test/keypad_entry_tb.sv
`timescale 1ns/1ps
`include "keypad_config.svh"

module keypad_entry_tb
    import keypad_pkg::*;
();
    localparam int value_w     = `KP_VALUE_W;
    localparam int hold_cycles = 4 * `KP_SCAN_DWELL + 20;
    localparam int key_budget  = 60;                    // Long holds counted in full
    localparam int cycle_limit = key_budget * 2 * hold_cycles + 1000;

    logic       clk = 1'b0;
    logic       nRST;
    logic       enable;
    logic [3:0] rows;
    logic [3:0] cols;
    logic       req;
    logic       ack = 1'b0;
    entry_t     entry;

    logic       pressed;
    logic [1:0] p_row;
    logic [1:0] p_col;
    logic       hold_ack;
    logic       req_q = 1'b0;
    entry_t     ref_entry = '0;
    entry_t     exp_q[$];
    int         n_sent = 0;                             // Entries the host port accepted
    int         n_done = 0;                             // Handshakes finished by the host
    int         checks = 0;
    int         compare_errors = 0;
    int         stim_errors = 0;
    int         cycles = 0;
    int         seed = 32'hfcf5;

    keypad_entry_top dut (
        .clk    (clk),
        .nRST   (nRST),
        .enable (enable),
        .rows   (rows),
        .cols   (cols),
        .req    (req),
        .ack    (ack),
        .entry  (entry)
    );

    // A key shows on its row only while its column is driven low
    assign rows = (pressed && !cols[p_col]) ? (4'b0001 << p_row) : 4'b0000;

    always #2 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int find_key(input logic [7:0] k);
        string layout;
        int    pos;
        int    i;
        layout = "147*2580369#ABCD";                    // Column by column, row 0 first
        pos = -1;
        for (i = 0; i < 16; i++) begin
            if (layout[i] == k) pos = i;
        end
        return pos;
    endfunction

    // Entry rules applied to one key, busy taken from the handshake record
    function automatic void ref_key(input logic [7:0] k);
        if (k >= "0" && k <= "9") begin
            if (ref_entry.ndigits < 3'(`KP_MAX_DIGITS)) begin
                ref_entry.value   = ref_entry.value * value_w'(10) + value_w'(k - "0");
                ref_entry.ndigits = ref_entry.ndigits + 3'd1;
            end
        end else if (k >= "A" && k <= "D") begin
            ref_entry.cmd = k;
        end else if (k == "*") begin
            ref_entry = '0;
        end else if (k == "#" && n_sent == n_done) begin
            exp_q.push_back(ref_entry);
            ref_entry = '0;
            n_sent++;
        end
    endfunction

    task automatic press_key(input logic [7:0] k, input int hold);
        int idx;
        idx = find_key(k);
        if (idx < 0) begin
            $display("Key sequence asks for %c, which the keypad does not have", k);
            stim_errors++;
        end else begin
            p_row   = idx[1:0];
            p_col   = idx[3:2];
            pressed = 1'b1;
            ref_key(k);
            repeat (hold) next_cycle();
            pressed = 1'b0;
            repeat (hold_cycles) next_cycle();
        end
    endtask

    task automatic type_keys(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            press_key(s[i], hold_cycles);
        end
    endtask

    // Host side, ack after 1 to 8 cycles unless held back
    initial begin
        int ack_delay;
        forever begin
            next_cycle();
            if (req) begin
                ack_delay = ($random(seed) & 32'h7) + 1;
                repeat (ack_delay - 1) next_cycle();
                while (hold_ack) next_cycle();
                ack = 1'b1;
                while (req) next_cycle();
                ack = 1'b0;
                n_done++;
            end
        end
    end

    // Each new request must carry the next expected entry
    initial begin
        entry_t exp_e;
        forever begin
            next_cycle();
            if (req && !req_q) begin
                if (exp_q.size() == 0) begin
                    $display("Request at %0t arrived with no entry expected", $time);
                    compare_errors++;
                end else begin
                    exp_e = exp_q.pop_front();
                    checks++;
                    if (entry !== exp_e) begin
                        $display("CHECK FAILED at %0t: entry %0d/%0d/%h, expected %0d/%0d/%h",
                                 $time, entry.value, entry.ndigits, entry.cmd,
                                 exp_e.value, exp_e.ndigits, exp_e.cmd);
                        compare_errors++;
                    end
                end
            end
            req_q = req;
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, run still busy after %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int         idx;
        logic [3:0] cols_frozen;
        nRST     = 1'b0;
        enable   = 1'b1;
        pressed  = 1'b0;
        p_row    = 2'd0;
        p_col    = 2'd0;
        hold_ack = 1'b0;
        repeat (10) next_cycle();
        nRST = 1'b1;
        repeat (4) next_cycle();

        type_keys("1234#");                             // Every digit key, no cmd
        type_keys("5678#");
        type_keys("90#");
        type_keys("12B#");
        type_keys("45C*78#");                           // Clear wipes digits and letter
        type_keys("A9#");
        type_keys("123456#");                           // Only the first four digits
        type_keys("#");
        press_key("3", 6 * hold_cycles);                // Long hold counts once
        type_keys("3#");

        hold_ack = 1'b1;                                // Second # lands while busy
        type_keys("12#");
        type_keys("34#");
        hold_ack = 1'b0;
        while (n_sent != n_done) next_cycle();
        repeat (4) next_cycle();
        type_keys("#");

        type_keys("7");
        enable = 1'b0;
        next_cycle();
        cols_frozen = cols;
        idx = find_key("5");
        p_row = idx[1:0];
        p_col = idx[3:2];
        pressed = 1'b1;                                 // Not in the reference, must be lost
        repeat (hold_cycles) begin
            next_cycle();
            if (cols !== cols_frozen) begin
                $display("CHECK FAILED at %0t: cols moved to %b while disabled", $time, cols);
                stim_errors++;
            end
        end
        pressed = 1'b0;
        repeat (4) next_cycle();
        enable = 1'b1;
        type_keys("#");
        while (n_sent != n_done) next_cycle();
        repeat (10) next_cycle();

        $display("compare errors: %0d, sequence errors: %0d, entries checked: %0d of %0d",
                 compare_errors, stim_errors, checks, n_sent);
        if (compare_errors == 0 && stim_errors == 0 && checks == n_sent
            && exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: keypad_entry_top.f
+incdir+design
design/keypad_pkg.sv
design/keypad_scan.sv
design/key_decode.sv
design/entry_assemble.sv
design/host_port.sv
design/keypad_entry_top.sv
test/keypad_entry_sva.sv
test/keypad_entry_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module keypad_entry_tb \
    -f keypad_entry_top.f -o keypad_entry_sim &&
./obj_dir/keypad_entry_sim | tee /dev/stderr | grep -qx "TEST RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
